//--- common/tl_unc_pkg.sv
// shared TileLink-UL widths, opcodes and request/response structs for the uncached path
package tl_unc_pkg;

    localparam int unsigned TL_DATA_W = 128;
    localparam int unsigned TL_ADDR_W = 32;
    localparam int unsigned TL_LANES  = 4;           // 32-bit words per beat
    localparam int unsigned TL_MASK_W = TL_DATA_W / 8;
    localparam int unsigned SOURCE_W  = 2;

    // channel A codes follow TileLink-UL
    // D codes sit apart so both channels share one enum
    typedef enum logic [2:0] {
        PUT_FULL_DATA    = 3'd0,
        PUT_PARTIAL_DATA = 3'd1,
        GET              = 3'd4,
        ACCESS_ACK       = 3'd6,
        ACCESS_ACK_DATA  = 3'd7
    } tl_opcode_e;

    typedef struct packed {
        logic                 write;
        logic [1:0]           size;   // 0 byte, 1 half, 2 word
        logic [TL_ADDR_W-1:0] addr;
        logic [31:0]          wdata;  // already in byte position within the word
    } cpu_req_t;

    typedef struct packed {
        tl_opcode_e           opcode;
        logic [1:0]           size;
        logic [TL_ADDR_W-1:0] addr;
        logic [TL_MASK_W-1:0] mask;
        logic [TL_DATA_W-1:0] data;
        logic [1:0]           lane;   // word lane inside the beat
    } unc_req_t;

    typedef struct packed {
        tl_opcode_e           opcode;
        logic [2:0]           param;
        logic [1:0]           size;
        logic [SOURCE_W-1:0]  source;
        logic [TL_ADDR_W-1:0] address;
        logic [TL_MASK_W-1:0] mask;
        logic [TL_DATA_W-1:0] data;
    } tl_a_t;

    typedef struct packed {
        tl_opcode_e           opcode;
        logic [1:0]           size;
        logic [SOURCE_W-1:0]  source;
        logic                 denied;
        logic [TL_DATA_W-1:0] data;
    } tl_d_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;     // set from D denied
    } cpu_resp_t;

endpackage

//--- hdl/bus_req_frontend.sv
// CPU request register, forms opcode, byte mask and lane data for the uncached queue
`timescale 1ns/1ps

module bus_req_frontend import tl_unc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  cpu_req_t req_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output unc_req_t out_o
);

    logic       vld_q;
    unc_req_t   req_q;
    unc_req_t   formed;
    logic [3:0] strb;
    logic [1:0] lane;
    logic       accept;

    assign lane = req_i.addr[3:2];

    // byte strobe inside the 32-bit word
    always_comb begin
        case (req_i.size)
            2'd0: begin
                case (req_i.addr[1:0])
                    2'd0:    strb = 4'b0001;
                    2'd1:    strb = 4'b0010;
                    2'd2:    strb = 4'b0100;
                    default: strb = 4'b1000;
                endcase
            end
            2'd1:    strb = req_i.addr[1] ? 4'b1100 : 4'b0011;
            default: strb = 4'b1111;    // word
        endcase
    end

    always_comb begin
        formed      = '0;
        formed.size = req_i.size;
        formed.addr = req_i.addr;
        formed.lane = lane;
        formed.mask[lane*4 +: 4]  = strb;         // other lanes stay zero
        formed.data[lane*32 +: 32] = req_i.wdata;
        if (!req_i.write) begin
            formed.opcode = GET;
        end else if (req_i.size == 2'd2) begin
            formed.opcode = PUT_FULL_DATA;
        end else begin
            formed.opcode = PUT_PARTIAL_DATA;
        end
    end

    // empty, or draining this cycle
    assign req_ready_o = !vld_q || out_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else if (accept) begin
            vld_q <= 1'b1;
        end else if (out_ready_i) begin
            vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= formed;
        end
    end

    assign out_valid_o = vld_q;
    assign out_o       = req_q;

endmodule

//--- hdl/req_fifo.sv
// circular queue of formed uncached requests between front end and TileLink engine
`timescale 1ns/1ps

module req_fifo import tl_unc_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4     // power of two
)(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  unc_req_t in_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output unc_req_t out_o
);

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    unc_req_t   mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic       full, empty;
    logic       push, pop;

    assign full  = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty = (count_q == '0);

    assign out_valid_o = !empty;
    assign in_ready_o  = !full || out_ready_i;  // full but popping still takes one
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= in_i;
        end
    end

    assign out_o = mem[rd_ptr_q];

endmodule

//--- tl_uncached/tl_uncached_engine.sv
// uncached TileLink-UL engine, one Get or Put at a time from queue to channel A, D back to CPU
`timescale 1ns/1ps

module tl_uncached_engine import tl_unc_pkg::*; #(
    parameter int unsigned SOURCE_ID = 1
)(
    input  logic      clk,
    input  logic      rst_n,
    // request queue
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  unc_req_t  req_i,
    // channel A
    output logic      tl_a_valid_o,
    input  logic      tl_a_ready_i,
    output tl_a_t     tl_a_o,
    // channel D
    input  logic      tl_d_valid_i,
    output logic      tl_d_ready_o,
    input  tl_d_t     tl_d_i,
    // cpu response
    output logic      resp_valid_o,
    input  logic      resp_ready_i,
    output cpu_resp_t resp_o
);

    localparam logic [SOURCE_W-1:0] SRC = SOURCE_W'(SOURCE_ID);

    typedef enum logic [1:0] {
        S_IDLE,
        S_A,      // channel A held until accepted
        S_D,      // waiting for our D beat
        S_RESP    // response held for the CPU
    } state_e;

    state_e    state_q;
    unc_req_t  req_q;
    cpu_resp_t resp_q;
    logic      d_hit;

    // beat for this source only
    assign d_hit = tl_d_valid_i && (tl_d_i.source == SRC);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= S_A;
                    end
                end
                S_A: begin
                    if (tl_a_ready_i) begin
                        state_q <= S_D;
                    end
                end
                S_D: begin
                    if (d_hit) begin
                        state_q <= S_RESP;
                    end
                end
                default: begin
                    if (resp_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_valid_i) begin
            req_q <= req_i;
        end
        if (state_q == S_D && d_hit) begin
            // stores carry the lane too, cpu drops it
            resp_q.rdata <= tl_d_i.data[req_q.lane*32 +: 32];
            resp_q.err   <= tl_d_i.denied;
        end
    end

    assign req_ready_o = (state_q == S_IDLE);

    always_comb begin
        tl_a_o         = '0;
        tl_a_o.opcode  = req_q.opcode;
        tl_a_o.param   = 3'd0;
        tl_a_o.size    = req_q.size;
        tl_a_o.source  = SRC;
        tl_a_o.address = req_q.addr;
        tl_a_o.mask    = req_q.mask;
        tl_a_o.data    = req_q.data;
    end

    assign tl_a_valid_o = (state_q == S_A);
    assign tl_d_ready_o = (state_q == S_D);
    assign resp_valid_o = (state_q == S_RESP);
    assign resp_o       = resp_q;

endmodule

//--- hdl/wired_tl_uncached.sv
// uncached TileLink-UL master top, turns CPU loads and stores into single-beat A/D transactions
`timescale 1ns/1ps

module wired_tl_uncached import tl_unc_pkg::*; #(
    parameter int unsigned SOURCE_ID  = 1,
    parameter int unsigned FIFO_DEPTH = 4
)(
    input  logic      clk,
    input  logic      rst_n,
    // cpu side
    input  logic      cpu_req_valid_i,
    output logic      cpu_req_ready_o,
    input  cpu_req_t  cpu_req_i,
    output logic      cpu_resp_valid_o,
    input  logic      cpu_resp_ready_i,
    output cpu_resp_t cpu_resp_o,
    // tilelink side
    output logic      tl_a_valid_o,
    input  logic      tl_a_ready_i,
    output tl_a_t     tl_a_o,
    input  logic      tl_d_valid_i,
    output logic      tl_d_ready_o,
    input  tl_d_t     tl_d_i
);

    logic     fe_valid, fe_ready;   // front end -> fifo
    unc_req_t fe_req;
    logic     fq_valid, fq_ready;   // fifo -> engine
    unc_req_t fq_req;

    bus_req_frontend u_frontend (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (cpu_req_valid_i),
        .req_ready_o (cpu_req_ready_o),
        .req_i       (cpu_req_i),
        .out_valid_o (fe_valid),
        .out_ready_i (fe_ready),
        .out_o       (fe_req)
    );

    req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (fe_valid),
        .in_ready_o  (fe_ready),
        .in_i        (fe_req),
        .out_valid_o (fq_valid),
        .out_ready_i (fq_ready),
        .out_o       (fq_req)
    );

    tl_uncached_engine #(
        .SOURCE_ID (SOURCE_ID)
    ) u_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (fq_valid),
        .req_ready_o  (fq_ready),
        .req_i        (fq_req),
        .tl_a_valid_o (tl_a_valid_o),
        .tl_a_ready_i (tl_a_ready_i),
        .tl_a_o       (tl_a_o),
        .tl_d_valid_i (tl_d_valid_i),
        .tl_d_ready_o (tl_d_ready_o),
        .tl_d_i       (tl_d_i),
        .resp_valid_o (cpu_resp_valid_o),
        .resp_ready_i (cpu_resp_ready_i),
        .resp_o       (cpu_resp_o)
    );

endmodule

//--- testbench/tb_tl_slave_model.sv
// TileLink-UL memory slave for the testbench, random A back-pressure and D delay
`timescale 1ns/1ps

module tb_tl_slave_model import tl_unc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  a_valid_i,
    output logic  a_ready_o,
    input  tl_a_t a_i,
    output logic  d_valid_o,
    input  logic  d_ready_i,
    output tl_d_t d_o
);

    logic [31:0] mem [64];     // 16 lines of four words
    logic [31:0] rnd;
    tl_a_t       a_hold;
    logic        a_fire;
    logic        d_fire;
    logic        pend;         // D beat owed
    int          delay;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic serve_request(input tl_a_t a);
        int base;
        base = a.address[7:4] * 4;
        d_o = '0;
        d_o.source = a.source;
        d_o.size = a.size;
        d_o.opcode = (a.opcode == GET) ? ACCESS_ACK_DATA : ACCESS_ACK;
        if (a.address[31:28] == 4'hF) begin
            d_o.denied = 1'b1;   // memory untouched
        end else if (a.opcode == GET) begin
            for (int l = 0; l < 4; l++) begin
                d_o.data[l*32 +: 32] = mem[base + l];
            end
        end else begin
            for (int b = 0; b < 16; b++) begin
                if (a.mask[b]) begin
                    mem[base + b/4][(b%4)*8 +: 8] = a.data[b*8 +: 8];
                end
            end
        end
    endtask

    initial begin
        for (int w = 0; w < 64; w++) begin
            mem[w] = (w * 32'h0101_0101) ^ 32'hA5A5_A5A5;
        end
        rnd = 32'd39;
        a_ready_o = 1'b0;
        d_valid_o = 1'b0;
        d_o = '0;
        a_fire = 1'b0;
        d_fire = 1'b0;
        pend = 1'b0;
        delay = 0;
    end

    // handshakes are settled by the falling edge
    always @(negedge clk) begin
        a_fire = a_valid_i && a_ready_o;
        d_fire = d_valid_o && d_ready_i;
        if (a_fire) begin
            a_hold = a_i;
        end
    end

    always @(posedge clk) begin
        #1;
        rnd = lcg_next(rnd);
        if (!rst_n) begin
            a_ready_o = 1'b0;
            d_valid_o = 1'b0;
            pend = 1'b0;
        end else begin
            if (d_fire) begin
                d_valid_o = 1'b0;
                pend = 1'b0;
            end
            if (a_fire) begin
                serve_request(a_hold);
                pend = 1'b1;
                delay = rnd[17:16];   // 0 to 3 cycles
            end
            if (pend && !d_valid_o) begin
                if (delay == 0) begin
                    d_valid_o = 1'b1;
                end else begin
                    delay--;
                end
            end
            a_ready_o = !pend && rnd[24];
        end
    end

endmodule

//--- testbench/tb_wired_tl_uncached.sv
// testbench for the uncached TileLink path, golden-file requests against a memory slave model
`timescale 1ns/1ps

module tb_wired_tl_uncached import tl_unc_pkg::*; ();

    localparam int SOURCE_ID  = 1;
    localparam int FIFO_DEPTH = 4;
    localparam int MAX_VEC    = 32;
    localparam int FIELDS     = 9;     // words per golden line
    localparam int TIMEOUT    = 400;   // cycles per wait

    logic      clk;
    logic      rst_n;
    logic      cpu_req_valid;
    logic      cpu_req_ready;
    cpu_req_t  cpu_req;
    logic      cpu_resp_valid;
    logic      cpu_resp_ready;
    cpu_resp_t cpu_resp;
    logic      tl_a_valid;
    logic      tl_a_ready;
    tl_a_t     tl_a;
    logic      tl_d_valid;
    logic      tl_d_ready;
    tl_d_t     tl_d;

    logic [31:0] gold [MAX_VEC*FIELDS];
    tl_a_t       a_seen [$];           // A transfers not yet matched to a response
    int          n_vec;
    int          resp_cnt;
    int          err_cnt;
    int          fail_cnt;
    logic        timed_out;
    logic        saw_req_stall;
    logic        extra_resp;
    logic [31:0] rnd;

    wired_tl_uncached #(
        .SOURCE_ID  (SOURCE_ID),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .cpu_req_valid_i  (cpu_req_valid),
        .cpu_req_ready_o  (cpu_req_ready),
        .cpu_req_i        (cpu_req),
        .cpu_resp_valid_o (cpu_resp_valid),
        .cpu_resp_ready_i (cpu_resp_ready),
        .cpu_resp_o       (cpu_resp),
        .tl_a_valid_o     (tl_a_valid),
        .tl_a_ready_i     (tl_a_ready),
        .tl_a_o           (tl_a),
        .tl_d_valid_i     (tl_d_valid),
        .tl_d_ready_o     (tl_d_ready),
        .tl_d_i           (tl_d)
    );

    tb_tl_slave_model u_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_valid_i (tl_a_valid),
        .a_ready_o (tl_a_ready),
        .a_i       (tl_a),
        .d_valid_o (tl_d_valid),
        .d_ready_i (tl_d_ready),
        .d_o       (tl_d)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] gold_word(input int idx, input int k);
        return gold[idx*FIELDS + k];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        fail_cnt++;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && tl_a_valid && tl_a_ready) begin
            a_seen.push_back(tl_a);
        end
        if (rst_n && cpu_resp_valid && !cpu_resp_ready && !cpu_req_ready) begin
            saw_req_stall = 1'b1;
        end
    end

    task automatic wait_responses(input int n);
        int t;
        t = 0;
        while (resp_cnt < n && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        assert (resp_cnt >= n) else begin
            report_failure($sformatf("response %0d did not arrive in time", n - 1));
            timed_out = 1'b1;
        end
    endtask

    task automatic send_request(input int idx);
        int t;
        cpu_req_valid = 1'b1;
        cpu_req.write = (gold_word(idx, 1) != 0);
        cpu_req.size = 2'(gold_word(idx, 2));
        cpu_req.addr = gold_word(idx, 3);
        cpu_req.wdata = gold_word(idx, 4);
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!cpu_req_ready && t < TIMEOUT);
        assert (cpu_req_ready) else begin
            report_failure($sformatf("request %0d was never accepted", idx));
            timed_out = 1'b1;
        end
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b0;
    endtask

    task automatic collect_response(input int idx);
        int    t;
        tl_a_t a;
        t = 0;
        do begin
            @(posedge clk);
            #1;
            rnd = lcg_next(rnd);
            // burst lines stall the response most of the time
            cpu_resp_ready = (gold_word(idx, 0) != 0) ? (rnd[22:20] == 3'd0) : 1'b1;
            @(negedge clk);
            t++;
        end while (!(cpu_resp_valid && cpu_resp_ready) && t < TIMEOUT);
        assert (cpu_resp_valid && cpu_resp_ready) else begin
            report_failure($sformatf("no response for request %0d", idx));
            timed_out = 1'b1;
        end
        if (!timed_out) begin
            compare_value($sformatf("cpu_resp_o.err, request %0d", idx), cpu_resp.err,
                          gold_word(idx, 8));
            if (gold_word(idx, 1) == 0 && gold_word(idx, 8) == 0) begin
                compare_value($sformatf("cpu_resp_o.rdata, request %0d", idx),
                              cpu_resp.rdata, gold_word(idx, 7));
            end
            assert (a_seen.size() > 0) else begin
                report_failure($sformatf("no channel A transfer for request %0d", idx));
            end
            if (a_seen.size() > 0) begin
                a = a_seen.pop_front();
                compare_value($sformatf("tl_a_o.opcode, request %0d", idx), a.opcode,
                              gold_word(idx, 5));
                compare_value($sformatf("tl_a_o.mask, request %0d", idx), a.mask,
                              gold_word(idx, 6));
                compare_value($sformatf("tl_a_o.source, request %0d", idx), a.source,
                              SOURCE_ID);
                compare_value($sformatf("tl_a_o.address, request %0d", idx), a.address,
                              gold_word(idx, 3));
                compare_value($sformatf("tl_a_o.size, request %0d", idx), a.size,
                              gold_word(idx, 2));
                compare_value($sformatf("tl_a_o.param, request %0d", idx), a.param, 0);
            end
            resp_cnt++;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req = '0;
        cpu_resp_ready = 1'b0;
        err_cnt = 0;
        fail_cnt = 0;
        resp_cnt = 0;
        timed_out = 1'b0;
        saw_req_stall = 1'b0;
        extra_resp = 1'b0;
        rnd = 32'd39;
        $readmemh("testbench/golden_requests.txt", gold);
        n_vec = 0;
        while (n_vec < MAX_VEC && gold_word(n_vec, 0) != 32'hF) begin
            n_vec++;
        end
        assert (n_vec > 0 && n_vec < MAX_VEC) else begin
            report_failure("golden file missing, empty or without end line");
            n_vec = 0;
        end

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("cpu_resp_valid_o after reset", cpu_resp_valid, 0);
        compare_value("tl_a_valid_o after reset", tl_a_valid, 0);
        compare_value("tl_d_ready_o after reset", tl_d_ready, 0);
        @(posedge clk);
        #1;

        fork
            begin
                for (int i = 0; i < n_vec; i++) begin
                    if (gold_word(i, 0) == 0) begin
                        wait_responses(i);   // single mode, one request in flight
                    end
                    if (timed_out) begin
                        break;
                    end
                    send_request(i);
                end
            end
            begin
                for (int i = 0; i < n_vec; i++) begin
                    collect_response(i);
                    if (timed_out) begin
                        break;
                    end
                end
            end
        join

        @(posedge clk);
        #1;
        cpu_resp_ready = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (cpu_resp_valid) begin
                extra_resp = 1'b1;
            end
        end
        assert (!extra_resp) else report_failure("response seen with no request outstanding");
        assert (a_seen.size() == 0) else report_failure("channel A transfer without a response");
        assert (saw_req_stall) else begin
            report_failure("cpu_req_ready_o never fell while a response was stalled");
        end

        $display("error counts: %0d wrong values, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- build.f
common/tl_unc_pkg.sv
hdl/bus_req_frontend.sv
hdl/req_fifo.sv
tl_uncached/tl_uncached_engine.sv
hdl/wired_tl_uncached.sv
testbench/tb_tl_slave_model.sv
testbench/tb_wired_tl_uncached.sv

//--- Bender.yml
package:
  name: wired_tl_uncached

sources:
  - common/tl_unc_pkg.sv
  - hdl/bus_req_frontend.sv
  - hdl/req_fifo.sv
  - tl_uncached/tl_uncached_engine.sv
  - hdl/wired_tl_uncached.sv
  - target: test
    files:
      - testbench/tb_tl_slave_model.sv
      - testbench/tb_wired_tl_uncached.sv

//--- testbench/golden_requests.txt
// columns: mode (0 single, 1 burst) write size addr wdata, then expected a_opcode a_mask rdata err
// a line with mode f ends the list
0 0 2 00000010 00000000 4 000F A1A1A1A1 0
0 1 0 00000025 00003C00 1 0020 00000000 0
0 0 2 00000024 00000000 4 00F0 ACAC3CAC 0
0 1 1 0000003A BEEF0000 1 0C00 00000000 0
0 0 2 00000038 00000000 4 0F00 BEEFABAB 0
0 1 2 0000004C 12345678 0 F000 00000000 0
0 0 2 0000004C 00000000 4 F000 12345678 0
0 0 0 00000026 00000000 4 0040 ACAC3CAC 0
0 1 0 F0000024 000000FF 1 0010 00000000 1
0 0 2 F0000024 00000000 4 00F0 00000000 1
0 0 2 00000024 00000000 4 00F0 ACAC3CAC 0
0 1 1 00000050 00005A5A 1 0003 00000000 0
1 0 2 00000050 00000000 4 000F B1B15A5A 0
1 1 2 00000060 CAFEF00D 0 000F 00000000 0
1 0 2 00000060 00000000 4 000F CAFEF00D 0
1 1 0 00000067 77000000 1 0080 00000000 0
1 0 2 00000064 00000000 4 00F0 77BCBCBC 0
1 0 2 000000FC 00000000 4 F000 9A9A9A9A 0
1 0 2 F0000080 00000000 4 000F 00000000 1
1 0 2 00000010 00000000 4 000F A1A1A1A1 0
f 0 0 00000000 00000000 0 0000 00000000 0
